// ==== flist.f ====
design/axi_read_pkg.sv
design/window_pkg.sv
design/row_fetch_ctrl.sv
design/row_buffer.sv
design/window_scan.sv
design/stream_fifo.sv
design/layer_reader_top.sv
tb/tb_clock_gen.sv
tb/axi_mem_model.sv
tb/tb_layer_reader.sv

// ==== tb/tb_layer_reader.sv ====
`timescale 1ns/10ps

module tb_layer_reader import axi_read_pkg::*, window_pkg::*; ();

	typedef struct packed {
		layer_t     layers;
		dim_t       rows;
		dim_t       cols;
		axi_addr_t  base;
		logic [7:0] ready_low_pct;
	} job_t;

	localparam int NUM_JOBS = 5;
	localparam int DONE_TIMEOUT = 400000;
	localparam int DRAIN_TIMEOUT = 20000;

	// layers, rows, cols, base address, percent of cycles with ready low
	job_t jobs [NUM_JOBS] = '{
		'{8'd1, 7'd4, 7'd8, 32'h0001_0000, 8'd0},
		'{8'd3, 7'd5, 7'd16, 32'h0003_0000, 8'd30},
		'{8'd2, 7'd3, 7'd1, 32'h0004_0000, 8'd20},
		'{8'd2, 7'd1, 7'd64, 32'h0080_0000, 8'd50},
		'{8'd1, 7'd64, 7'd64, 32'h0010_0000, 8'd10}
	};

	logic      clk;
	logic      reset_n;
	logic      start;
	axi_addr_t base_addr;
	layer_t    num_layers;
	dim_t      num_rows;
	dim_t      num_cols;
	axi_addr_t araddr;
	logic      arvalid;
	logic      arready;
	axi_data_t rdata;
	logic      rvalid;
	logic      rlast;
	logic      rready;
	window_t   window_data;
	logic      window_valid;
	logic      window_ready;
	logic      busy;
	logic      done;
	logic      proto_error;

	axi_addr_t exp_addr [$];
	window_t   exp_win [$];
	int        done_cnt;
	int        ready_low_pct;

	tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) clkgen0 (.clk(clk), .reset_n(reset_n));

	axi_mem_model mem0 (
		.clk(clk), .reset_n(reset_n), .araddr(araddr), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
		.rready(rready), .proto_error(proto_error)
	);

	layer_reader_top dut0 (
		.clk(clk), .reset_n(reset_n), .start(start), .base_addr(base_addr),
		.num_layers(num_layers), .num_rows(num_rows), .num_cols(num_cols),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
		.rvalid(rvalid), .rlast(rlast), .rready(rready), .window_data(window_data),
		.window_valid(window_valid), .window_ready(window_ready), .busy(busy), .done(done)
	);

	// ------------------------------------------------------------------
	// error exit and compare tasks
	// ------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_window(input string name, input window_t got, input window_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input dim_t got, input dim_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// ------------------------------------------------------------------
	// reference image and expected streams
	// ------------------------------------------------------------------
	function automatic pixel_t image_pixel(input job_t job, input int layer, input int row,
		input int col);
		axi_addr_t a;
		if (row < 0 || row >= int'(job.rows) || col < 0 || col >= int'(job.cols))
			return '0;
		a = job.base + axi_addr_t'(layer * 4096 + row * 64 + col);
		return a[7:0] ^ a[19:12];
	endfunction

	// byte 3*i+j is row offset i, column offset j
	function automatic window_t expected_window(input job_t job, input int layer, input int row,
		input int col);
		window_t w;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				w[(3 * i + j) * 8 +: 8] = image_pixel(job, layer, row + i - 1, col + j - 1);
			end
		end
		return w;
	endfunction

	// output row outer, layer middle, column inner
	task automatic queue_expected(input job_t job);
		int src;
		for (int r = 0; r < int'(job.rows); r++) begin
			for (int l = 0; l < int'(job.layers); l++) begin
				for (int i = 0; i < 3; i++) begin
					src = r + i - 1;
					if (src >= 0 && src < int'(job.rows))
						exp_addr.push_back(job.base + axi_addr_t'(l * 4096 + src * 64));
				end
				for (int c = 0; c < int'(job.cols); c++)
					exp_win.push_back(expected_window(job, l, r, c));
			end
		end
	endtask

	// ------------------------------------------------------------------
	// monitors and ready driver
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		if (proto_error)
			abort_run("memory model detected an AXI read protocol violation");
		if (arvalid && arready) begin
			if (exp_addr.size() == 0)
				abort_run("read burst issued where none was expected");
			else
				check_addr("araddr", araddr, exp_addr.pop_front());
		end
		if (window_valid && window_ready) begin
			if (exp_win.size() == 0)
				abort_run("window delivered beyond the expected count");
			else
				check_window("window_data", window_data, exp_win.pop_front());
		end
		if (done) begin
			done_cnt++;
			if (!busy)
				abort_run("busy low in the cycle of done");
		end
	end

	always @(negedge clk)
		window_ready <= ($urandom_range(99) >= ready_low_pct);

	// ------------------------------------------------------------------
	// job sequence
	// ------------------------------------------------------------------
	initial begin
		int cyc;
		int done_before;
		void'($urandom(32'hf709_aed6));
		start = 1'b0;
		base_addr = '0;
		num_layers = 8'd1;
		num_rows = 7'd1;
		num_cols = 7'd1;
		window_ready = 1'b0;
		ready_low_pct = 0;
		done_cnt = 0;

		cyc = 0;
		while (reset_n !== 1'b1 && cyc < 100) begin
			@(negedge clk);
			cyc++;
		end
		if (reset_n !== 1'b1)
			abort_run("reset_n was never released");

		// outputs stay quiet until the first start
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			if (window_valid || arvalid || rready || done || busy)
				abort_run("DUT output active after reset without a start");
		end

		foreach (jobs[n]) begin
			queue_expected(jobs[n]);
			ready_low_pct = jobs[n].ready_low_pct;
			done_before = done_cnt;
			@(negedge clk);
			base_addr = jobs[n].base;
			num_layers = jobs[n].layers;
			num_rows = jobs[n].rows;
			num_cols = jobs[n].cols;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;

			cyc = 0;
			while (done_cnt == done_before && cyc < DONE_TIMEOUT) begin
				@(negedge clk);
				cyc++;
				if (done_cnt == done_before && !busy)
					abort_run($sformatf("busy low during job %0d before done", n));
			end
			if (done_cnt == done_before)
				abort_run($sformatf("job %0d never signalled done", n));

			// windows may still sit in the FIFO after done
			cyc = 0;
			while (exp_win.size() != 0 && cyc < DRAIN_TIMEOUT) begin
				@(negedge clk);
				cyc++;
			end
			if (exp_win.size() != 0)
				abort_run($sformatf("job %0d is missing %0d windows", n, exp_win.size()));

			ready_low_pct = 0;
			for (int k = 0; k < 20; k++) begin
				@(negedge clk);
				if (window_valid || busy || arvalid)
					abort_run($sformatf("DUT not idle after job %0d", n));
			end
			check_count("done_pulses", dim_t'(done_cnt - done_before), 7'd1);
			if (exp_addr.size() != 0)
				abort_run($sformatf("job %0d left %0d reads unissued", n, exp_addr.size()));
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tb/axi_mem_model.sv ====
`timescale 1ns/10ps

module axi_mem_model import axi_read_pkg::*; #(
	parameter int STALL_PCT = 25
) (
	input  logic      clk,
	input  logic      reset_n,
	input  axi_addr_t araddr,
	input  logic      arvalid,
	output logic      arready,
	output axi_data_t rdata,
	output logic      rvalid,
	output logic      rlast,
	input  logic      rready,
	output logic      proto_error
);

	logic      bursting;
	logic      ar_taken;
	logic      r_taken;
	axi_addr_t burst_addr;
	beat_idx_t beat;

	// byte at address a is a[7:0] xor a[19:12]
	function automatic axi_data_t beat_bytes(input axi_addr_t a);
		axi_data_t d;
		axi_addr_t b;
		for (int k = 0; k < BYTES_PER_BEAT; k++) begin
			b = a + axi_addr_t'(k);
			d[8 * k +: 8] = b[7:0] ^ b[19:12];
		end
		return d;
	endfunction

	task automatic note_violation(input string what);
		$display("memory model: %s, araddr 0x%h", what, araddr);
		proto_error = 1'b1;
	endtask

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		proto_error = 1'b0;
		bursting = 1'b0;
		ar_taken = 1'b0;
		r_taken = 1'b0;
		burst_addr = '0;
		beat = '0;
	end

	// decided on the falling edge, the DUT takes it on the next rising edge
	always @(negedge clk) begin
		if (!reset_n) begin
			bursting = 1'b0;
			ar_taken = 1'b0;
			r_taken = 1'b0;
			arready = 1'b0;
			rvalid = 1'b0;
			rlast = 1'b0;
		end else begin
			// retire what the last rising edge transferred
			if (r_taken) begin
				if (rlast)
					bursting = 1'b0;
				beat = beat + 3'd1;
			end
			if (ar_taken) begin
				bursting = 1'b1;
				beat = '0;
			end

			if (arvalid && bursting)
				note_violation("new address during a burst");
			if (arvalid && araddr[5:0] != 6'd0)
				note_violation("address not 64-byte aligned");

			arready = !bursting && ($urandom_range(99) >= STALL_PCT);
			ar_taken = arvalid && arready;
			if (ar_taken)
				burst_addr = araddr;

			rvalid = bursting && ($urandom_range(99) >= STALL_PCT);
			rlast = bursting && (beat == beat_idx_t'(BEATS_PER_ROW - 1));
			rdata = bursting ? beat_bytes(burst_addr + axi_addr_t'(beat) * BYTES_PER_BEAT) : '0;
			r_taken = rvalid && rready;
		end
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real PERIOD_NS = 8.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	// released on a falling edge like every other input
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

// ==== design/layer_reader_top.sv ====
`timescale 1ns/10ps

module layer_reader_top import axi_read_pkg::*, window_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      start,
	input  axi_addr_t base_addr,
	input  layer_t    num_layers,
	input  dim_t      num_rows,
	input  dim_t      num_cols,
	output axi_addr_t araddr,
	output logic      arvalid,
	input  logic      arready,
	input  axi_data_t rdata,
	input  logic      rvalid,
	input  logic      rlast,
	output logic      rready,
	output window_t   window_data,
	output logic      window_valid,
	input  logic      window_ready,
	output logic      busy,
	output logic      done
);

	// ------------------------------------------------------------------
	// internal links
	// ------------------------------------------------------------------
	logic      wr_en;
	bank_t     wr_bank;
	beat_idx_t wr_beat;
	axi_data_t wr_data;
	logic      scan_start;
	logic      scan_done;
	dim_t      rd_col;
	window_t   rd_block;
	logic      fifo_full;
	logic      push;
	window_t   push_data;

	row_fetch_ctrl fetch0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.base_addr  (base_addr),
		.num_layers (num_layers),
		.num_rows   (num_rows),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rlast      (rlast),
		.rready     (rready),
		.wr_en      (wr_en),
		.wr_bank    (wr_bank),
		.wr_beat    (wr_beat),
		.wr_data    (wr_data),
		.scan_start (scan_start),
		.scan_done  (scan_done),
		.busy       (busy),
		.done       (done)
	);

	row_buffer rows0 (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_bank  (wr_bank),
		.wr_beat  (wr_beat),
		.wr_data  (wr_data),
		.rd_col   (rd_col),
		.rd_block (rd_block)
	);

	window_scan scan0 (
		.clk        (clk),
		.reset_n    (reset_n),
		.scan_start (scan_start),
		.num_cols   (num_cols),
		.rd_col     (rd_col),
		.rd_block   (rd_block),
		.fifo_full  (fifo_full),
		.push       (push),
		.push_data  (push_data),
		.scan_done  (scan_done)
	);

	stream_fifo #(
		.DEPTH (8)
	) fifo0 (
		.clk          (clk),
		.reset_n      (reset_n),
		.push         (push),
		.push_data    (push_data),
		.full         (fifo_full),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready)
	);

endmodule

// ==== design/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo import window_pkg::*; #(
	parameter int DEPTH = 8
) (
	input  logic    clk,
	input  logic    reset_n,
	input  logic    push,
	input  window_t push_data,
	output logic    full,
	output window_t window_data,
	output logic    window_valid,
	input  logic    window_ready
);

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	window_t mem [DEPTH];
	ptr_t    wr_ptr;
	ptr_t    rd_ptr;
	cnt_t    count;
	logic    pop;

	// circular step, depth need not be a power of two
	function automatic ptr_t bump(input ptr_t ptr);
		if (ptr == ptr_t'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == cnt_t'(DEPTH));
	assign window_valid = (count != '0);
	assign window_data = mem[rd_ptr];
	assign pop = window_valid && window_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= bump(wr_ptr);
			if (pop) rd_ptr <= bump(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= push_data;
	end

	// the scanner must stall on full
	assert property (@(posedge clk) disable iff (!reset_n) push |-> !full)
		else $error("window pushed into a full FIFO");

endmodule

// ==== design/window_scan.sv ====
`timescale 1ns/10ps

module window_scan import window_pkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  logic    scan_start,
	input  dim_t    num_cols,
	output dim_t    rd_col,
	input  window_t rd_block,
	input  logic    fifo_full,
	output logic    push,
	output window_t push_data,
	output logic    scan_done
);

	logic active;
	logic at_last;
	dim_t col;
	dim_t cols_q;

	assign at_last = (col == cols_q - 7'd1);
	assign rd_col = col;
	assign push = active && !fifo_full;
	assign scan_done = push && at_last;

	// left and right padding against the real image width
	always_comb begin
		push_data = rd_block;
		for (int i = 0; i < WINDOW_ROWS; i++) begin
			if (col == '0)
				push_data[(WINDOW_ROWS * i) * $bits(pixel_t) +: $bits(pixel_t)] = '0;
			if (at_last)
				push_data[(WINDOW_ROWS * i + 2) * $bits(pixel_t) +: $bits(pixel_t)] = '0;
		end
	end

	// column walk, holds while the FIFO is full
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active <= 1'b0;
			col <= '0;
		end else if (scan_start) begin
			active <= 1'b1;
			col <= '0;
		end else if (push) begin
			if (at_last) active <= 1'b0;
			col <= at_last ? '0 : col + 7'd1;
		end
	end

	// width taken at each scan start
	always_ff @(posedge clk) begin
		if (scan_start) cols_q <= num_cols;
	end

endmodule

// ==== design/row_buffer.sv ====
`timescale 1ns/10ps

module row_buffer import axi_read_pkg::*, window_pkg::*; (
	input  logic      clk,
	input  logic      wr_en,
	input  bank_t     wr_bank,
	input  beat_idx_t wr_beat,
	input  axi_data_t wr_data,
	input  dim_t      rd_col,
	output window_t   rd_block
);

	// bank i holds the row at offset i, 0 is the row above
	axi_data_t banks [WINDOW_ROWS][BEATS_PER_ROW];
	pixel_t    row_px [WINDOW_ROWS][MAX_COLS];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			banks[wr_bank][wr_beat] <= wr_data;
		end
	end

	// byte lanes follow address order, column c sits in beat c/8
	always_comb begin
		for (int i = 0; i < WINDOW_ROWS; i++) begin
			for (int c = 0; c < MAX_COLS; c++) begin
				row_px[i][c] = banks[i][c / BYTES_PER_BEAT][(c % BYTES_PER_BEAT) * 8 +: 8];
			end
		end
	end

	// ------------------------------------------------------------------
	// 3x3 block around rd_col
	// ------------------------------------------------------------------
	always_comb begin
		logic [7:0]                  col_plus1;
		logic [$clog2(MAX_COLS)-1:0] col_idx;
		rd_block = '0;
		for (int j = 0; j < WINDOW_ROWS; j++) begin
			// column rd_col+j-1, kept offset by one to stay unsigned
			col_plus1 = {1'b0, rd_col} + 8'(j);
			col_idx = col_plus1[$clog2(MAX_COLS)-1:0] - 1'b1;
			if (col_plus1 != 8'd0 && col_plus1 <= 8'(MAX_COLS)) begin
				for (int i = 0; i < WINDOW_ROWS; i++) begin
					rd_block[(WINDOW_ROWS * i + j) * $bits(pixel_t) +: $bits(pixel_t)] =
						row_px[i][col_idx];
				end
			end
		end
	end

endmodule

// ==== design/row_fetch_ctrl.sv ====
`timescale 1ns/10ps

module row_fetch_ctrl import axi_read_pkg::*, window_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      start,
	input  axi_addr_t base_addr,
	input  layer_t    num_layers,
	input  dim_t      num_rows,
	output axi_addr_t araddr,
	output logic      arvalid,
	input  logic      arready,
	input  axi_data_t rdata,
	input  logic      rvalid,
	input  logic      rlast,
	output logic      rready,
	output logic      wr_en,
	output bank_t     wr_bank,
	output beat_idx_t wr_beat,
	output axi_data_t wr_data,
	output logic      scan_start,
	input  logic      scan_done,
	output logic      busy,
	output logic      done
);

	typedef enum logic [2:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_ZERO, ST_SCAN} state_t;

	state_t    state;
	axi_addr_t base_q;
	layer_t    layers_q;
	dim_t      rows_q;
	dim_t      out_row;
	layer_t    layer;
	bank_t     step;
	beat_idx_t beat;

	logic       accept;
	logic       beat_fire;
	logic       step_done;
	logic       last_step;
	logic       last_layer;
	logic       last_row;
	logic       launch;
	dim_t       nxt_row;
	layer_t     nxt_layer;
	bank_t      nxt_step;
	logic [7:0] src_plus1;
	logic       src_live;

	assign accept = (state == ST_IDLE) && start && !done;
	assign beat_fire = (state == ST_DATA) && rvalid;
	assign step_done = ((state == ST_ZERO) && (beat == beat_idx_t'(BEATS_PER_ROW - 1)))
		|| (beat_fire && rlast);
	assign last_step = (step == bank_t'(WINDOW_ROWS - 1));
	assign last_layer = (layer == layers_q - 8'd1);
	assign last_row = (out_row == rows_q - 7'd1);

	// ------------------------------------------------------------------
	// next fetch step: row offset, then layer, then output row
	// ------------------------------------------------------------------
	always_comb begin
		nxt_row = out_row;
		nxt_layer = layer;
		nxt_step = step + 2'd1;
		launch = 1'b0;
		case (state)
			ST_IDLE: begin
				nxt_row = '0;
				nxt_layer = '0;
				nxt_step = '0;
				launch = accept;
			end
			ST_DATA, ST_ZERO: launch = step_done && !last_step;
			ST_SCAN: begin
				nxt_step = '0;
				launch = scan_done && !(last_layer && last_row);
				if (last_layer) begin
					nxt_layer = '0;
					nxt_row = out_row + 7'd1;
				end else begin
					nxt_layer = layer + 8'd1;
				end
			end
			default: launch = 1'b0;
		endcase
	end

	// source row plus one, zero means the padding row above row 0
	assign src_plus1 = {1'b0, nxt_row} + {6'd0, nxt_step};
	assign src_live = (src_plus1 != 8'd0) && (src_plus1 <= {1'b0, rows_q});

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			out_row <= '0;
			layer <= '0;
			step <= '0;
			beat <= '0;
			scan_start <= 1'b0;
			done <= 1'b0;
		end else begin
			scan_start <= 1'b0;
			done <= 1'b0;
			case (state)
				ST_ADDR: if (arready) state <= ST_DATA;
				ST_DATA, ST_ZERO: begin
					// wraps back to 0 after the eighth beat
					if (wr_en) beat <= beat + 3'd1;
					if (step_done && last_step) begin
						state <= ST_SCAN;
						scan_start <= 1'b1;
					end
				end
				ST_SCAN: if (scan_done && last_layer && last_row) begin
					state <= ST_IDLE;
					done <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
			if (launch) begin
				out_row <= nxt_row;
				layer <= nxt_layer;
				step <= nxt_step;
				beat <= '0;
				state <= src_live ? ST_ADDR : ST_ZERO;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			base_q <= base_addr;
			layers_q <= num_layers;
			rows_q <= num_rows;
		end
		if (launch && src_live) begin
			araddr <= base_q + axi_addr_t'(nxt_layer) * axi_addr_t'(LAYER_PITCH_BYTES)
				+ axi_addr_t'(src_plus1 - 8'd1) * axi_addr_t'(ROW_PITCH_BYTES);
		end
	end

	assign arvalid = (state == ST_ADDR);
	assign rready = (state == ST_DATA);
	assign busy = (state != ST_IDLE) || done;

	// bank write port, padding rows get zero beats
	assign wr_en = (state == ST_ZERO) || beat_fire;
	assign wr_bank = step;
	assign wr_beat = beat;
	assign wr_data = (state == ST_DATA) ? rdata : '0;

	// memory must close the burst on the eighth beat and never earlier
	assert property (@(posedge clk) disable iff (!reset_n)
		(rvalid && rready) |-> (rlast == (beat == beat_idx_t'(BEATS_PER_ROW - 1))))
		else $error("rlast out of place on beat %0d", beat);

	assert property (@(posedge clk) disable iff (!reset_n)
		(arvalid && !arready) |=> (arvalid && $stable(araddr)))
		else $error("araddr changed while waiting for arready");

endmodule

// ==== design/window_pkg.sv ====
package window_pkg;

	// ------------------------------------------------------------------
	// pixel and window types
	// ------------------------------------------------------------------

	typedef logic [7:0] pixel_t;

	// nine pixels, byte 3*i+j is row offset i, column offset j
	typedef logic [71:0] window_t;

	// row or column count/index, up to 64
	typedef logic [6:0] dim_t;

	typedef logic [7:0] layer_t;

	// selects one of the three row banks
	typedef logic [1:0] bank_t;

	// ------------------------------------------------------------------
	// image geometry and memory layout
	// ------------------------------------------------------------------

	localparam int MAX_COLS = 64;
	localparam int WINDOW_ROWS = 3;

	// rows packed at 64 byte pitch, layers on 4 KiB boundaries
	localparam int ROW_PITCH_BYTES = 64;
	localparam int LAYER_PITCH_BYTES = 4096;

endpackage

// ==== design/axi_read_pkg.sv ====
package axi_read_pkg;

	// ------------------------------------------------------------------
	// read port widths
	// ------------------------------------------------------------------

	// byte address on the read address channel
	typedef logic [31:0] axi_addr_t;

	// one read data beat
	typedef logic [63:0] axi_data_t;

	// beat number inside one burst
	typedef logic [2:0] beat_idx_t;

	// ------------------------------------------------------------------
	// burst geometry
	// ------------------------------------------------------------------

	// one image row is exactly one INCR burst
	localparam int BEATS_PER_ROW = 8;

	// full-width beats, size field fixed at 3
	localparam int BYTES_PER_BEAT = 8;

endpackage
